/* hw/a12_filter.sv */
`timescale 1ns/10ps

module a12_filter #(
	parameter int FILTER_LEN = 3
) (
	input  logic a12d,
	input  logic ctr_reload,
	input  logic ppu_a12,
	output logic a12_rise,
	output logic a12_fall
);
	localparam int CNT_W = $clog2(FILTER_LEN + 1);

	logic             a12_meta;
	logic             a12_sync;
	logic             a12_level; // debounced copy of a12.
	logic [CNT_W-1:0] run_cnt;
	logic             flip;

	// level changes after FILTER_LEN samples that disagree with it.
	assign flip = (a12_sync != a12_level) && (run_cnt == CNT_W'(FILTER_LEN - 1));

	always_ff @(posedge a12d or posedge ctr_reload)
	begin
		if (ctr_reload)
		begin
			a12_meta  <= 1'b0;
			a12_sync  <= 1'b0;
			a12_level <= 1'b0;
			run_cnt   <= '0;
			a12_rise  <= 1'b0;
			a12_fall  <= 1'b0;
		end
		else
		begin
			a12_meta <= ppu_a12;
			a12_sync <= a12_meta;
			if (a12_sync == a12_level || flip)
				run_cnt <= '0; // short glitch restarts the run.
			else
				run_cnt <= run_cnt + 1'b1;
			if (flip)
				a12_level <= a12_sync;
			a12_rise <= flip && a12_sync;
			a12_fall <= flip && !a12_sync;
		end
	end

endmodule

/* hw/addr_translate.sv */
`timescale 1ns/10ps

module addr_translate (
	input  logic [15:0]     cpu_addr,
	input  logic [13:0]     ppu_addr,
	input  logic            wr_valid,
	input  logic [7:0][7:0] bank_data,
	input  logic            prg_mode,
	input  logic            chr_mode,
	input  logic            mirror_h,
	input  logic            ram_en,
	input  logic            ram_wp,
	input  logic            cfg_chr_ram,
	output logic [18:0]     prg_addr,
	output logic [17:0]     chr_addr,
	output logic            ciram_a10,
	output logic            ciram_ce,
	output logic            ram_ce,
	output logic            ram_we
);
	import mapper_pkg::*;

	localparam logic [PRG_BANK_W-1:0] PRG_LAST   = '1; // bank 3f.
	localparam logic [PRG_BANK_W-1:0] PRG_SECOND = {{(PRG_BANK_W - 1){1'b1}}, 1'b0};
	localparam int CHR_RAM_W = 5; // 32k of chr ram.

	logic [PRG_BANK_W-1:0] prg_bank;
	logic [PRG_BANK_W-1:0] prg_r6;
	logic [CHR_BANK_W-1:0] chr_sel;
	logic [CHR_BANK_W-1:0] chr_bank;
	logic                  in_2k;

	assign prg_r6 = bank_data[6][PRG_BANK_W-1:0];

	// four 8k slots, r6 swaps between $8000 and $c000.
	always_comb
	begin
		case (cpu_addr[14:13])
			2'd0:    prg_bank = prg_mode ? PRG_SECOND : prg_r6;
			2'd1:    prg_bank = bank_data[7][PRG_BANK_W-1:0];
			2'd2:    prg_bank = prg_mode ? prg_r6 : PRG_SECOND;
			default: prg_bank = PRG_LAST;
		endcase
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};

	// the 2k pair sits in the half chosen by chr_mode.
	assign in_2k = ppu_addr[12] == chr_mode;

	always_comb
	begin
		if (in_2k)
			chr_sel = {bank_data[{2'b00, ppu_addr[11]}][CHR_BANK_W-1:1], ppu_addr[10]};
		else
			chr_sel = bank_data[3'd2 + {1'b0, ppu_addr[11:10]}][CHR_BANK_W-1:0]; // r2..r5.
	end

	assign chr_bank = cfg_chr_ram ? {{(CHR_BANK_W - CHR_RAM_W){1'b0}}, chr_sel[CHR_RAM_W-1:0]}
	                              : chr_sel;
	assign chr_addr = {chr_bank, ppu_addr[9:0]};

	// nametables live in console ciram.
	assign ciram_a10 = mirror_h ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce  = !ppu_addr[13];

	// work ram at $6000..$7fff.
	assign ram_ce = ram_en && (cpu_addr[15:13] == 3'b011);
	assign ram_we = ram_ce && wr_valid && !ram_wp; // write protect blocks stores only.

endmodule

/* hw/bank_regs.sv */
`timescale 1ns/10ps

module bank_regs (
	input  logic                a12d,
	input  logic                ctr_reload,
	input  logic                wr_valid,
	input  logic [15:0]         cpu_addr,
	input  logic [7:0]          cpu_data,
	input  logic                ss_we,
	input  logic [7:0]          ss_addr,
	input  logic [7:0]          ss_wdata,
	input  logic [7:0]          irq_ss_rdata,
	input  logic                cfg_mir_v,
	output logic [7:0][7:0]     bank_data,
	output logic                prg_mode,
	output logic                chr_mode,
	output logic                mirror_h,
	output logic                ram_en,
	output logic                ram_wp,
	output mapper_pkg::reg_op_e irq_op,
	output logic [7:0]          irq_wdata,
	output logic [7:0]          ss_rdata
);
	import mapper_pkg::*;

	// power-on bank layout, bank 7 first.
	localparam logic [7:0][7:0] BANK_RST = {8'd1, 8'd0, 8'd7, 8'd6, 8'd5, 8'd4, 8'd2, 8'd0};

	reg_op_e    wr_op;
	logic       cpu_wr;
	logic [7:0] bank_sel;
	logic [7:0] mirror_reg;
	logic [7:0] ram_ctrl;

	assign cpu_wr = wr_valid && !ss_we; // a save-state write wins the cycle.

	always_comb
	begin
		wr_op = OP_NONE;
		if (cpu_wr)
		begin
			case ({cpu_addr[15:13], cpu_addr[0]})
				4'b100_0: wr_op = OP_BANK_SEL;
				4'b100_1: wr_op = OP_BANK_DATA;
				4'b101_0: wr_op = OP_MIRROR;
				4'b101_1: wr_op = OP_RAM_CTRL;
				4'b110_0: wr_op = OP_IRQ_LATCH;
				4'b110_1: wr_op = OP_IRQ_RELOAD;
				4'b111_0: wr_op = OP_IRQ_DISABLE;
				4'b111_1: wr_op = OP_IRQ_ENABLE;
				default:  wr_op = OP_NONE; // below $8000.
			endcase
		end
	end

	always_ff @(posedge a12d or posedge ctr_reload)
	begin
		if (ctr_reload)
		begin
			bank_data  <= BANK_RST;
			bank_sel   <= 8'd0;
			mirror_reg <= {7'd0, !cfg_mir_v};
			ram_ctrl   <= 8'd0; // work ram off after reset.
		end
		else if (ss_we)
		begin
			if (ss_addr[7:3] == 5'd0)
				bank_data[ss_addr[2:0]] <= ss_wdata;
			if (ss_addr == SS_BANK_SEL)
				bank_sel <= ss_wdata;
			if (ss_addr == SS_MIRROR)
				mirror_reg <= ss_wdata;
			if (ss_addr == SS_RAM_CTRL)
				ram_ctrl <= ss_wdata;
		end
		else
		begin
			case (wr_op)
				OP_BANK_SEL:  bank_sel <= cpu_data;
				OP_BANK_DATA: bank_data[bank_sel[2:0]] <= cpu_data; // target picked by $8000.
				OP_MIRROR:    mirror_reg <= cpu_data;
				OP_RAM_CTRL:  ram_ctrl <= cpu_data;
				default:      ;
			endcase
		end
	end

	assign prg_mode = bank_sel[6];
	assign chr_mode = bank_sel[7];
	assign mirror_h = mirror_reg[0];
	assign ram_en   = ram_ctrl[7];
	assign ram_wp   = ram_ctrl[6];

	// counter ops are forwarded undecoded by the irq block.
	assign irq_op    = wr_op;
	assign irq_wdata = cpu_data;

	// readback mux over the whole save-state space.
	always_comb
	begin
		if (ss_addr[7:3] == 5'd0)
			ss_rdata = bank_data[ss_addr[2:0]];
		else if (ss_addr == SS_BANK_SEL)
			ss_rdata = bank_sel;
		else if (ss_addr == SS_MIRROR)
			ss_rdata = mirror_reg;
		else if (ss_addr == SS_RAM_CTRL)
			ss_rdata = ram_ctrl;
		else if (ss_addr[7:3] == SS_IRQ_LATCH[7:3])
			ss_rdata = irq_ss_rdata; // 16..23.
		else
			ss_rdata = 8'hff;
	end

	// register state only moves on a write strobe.
	a_hold_without_write: assert property (@(posedge a12d) disable iff (ctr_reload)
		!wr_valid && !ss_we |=> $stable(bank_data) && $stable(bank_sel)
			&& $stable(mirror_reg) && $stable(ram_ctrl))
		else $error("bank state changed without a write strobe");

endmodule

/* hw/mapper_acclaim_top.sv */
`timescale 1ns/10ps

module mapper_acclaim_top #(
	parameter int FILTER_LEN = 3,
	parameter int EDGE_DIV   = 8
) (
	input  logic        a12d,
	input  logic        ctr_reload,
	input  logic        wr_valid,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_data,
	input  logic [13:0] ppu_addr,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	input  logic [7:0]  ss_wdata,
	input  logic        cfg_mir_v,
	input  logic        cfg_chr_ram,
	output logic [18:0] prg_addr,
	output logic [17:0] chr_addr,
	output logic        ciram_a10,
	output logic        ciram_ce,
	output logic        ram_ce,
	output logic        ram_we,
	output logic        irq,
	output logic [7:0]  ss_rdata
);
	import mapper_pkg::*;

	logic [7:0][7:0] bank_data;
	logic            prg_mode;
	logic            chr_mode;
	logic            mirror_h;
	logic            ram_en;
	logic            ram_wp;
	reg_op_e         irq_op;
	logic [7:0]      irq_wdata;
	logic [7:0]      irq_ss_rdata;
	logic            a12_rise;
	logic            a12_fall;

	bank_regs regs_i (
		.a12d         (a12d),
		.ctr_reload   (ctr_reload),
		.wr_valid     (wr_valid),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.ss_we        (ss_we),
		.ss_addr      (ss_addr),
		.ss_wdata     (ss_wdata),
		.irq_ss_rdata (irq_ss_rdata),
		.cfg_mir_v    (cfg_mir_v),
		.bank_data    (bank_data),
		.prg_mode     (prg_mode),
		.chr_mode     (chr_mode),
		.mirror_h     (mirror_h),
		.ram_en       (ram_en),
		.ram_wp       (ram_wp),
		.irq_op       (irq_op),
		.irq_wdata    (irq_wdata),
		.ss_rdata     (ss_rdata)
	);

	addr_translate xlate_i (
		.cpu_addr    (cpu_addr),
		.ppu_addr    (ppu_addr),
		.wr_valid    (wr_valid),
		.bank_data   (bank_data),
		.prg_mode    (prg_mode),
		.chr_mode    (chr_mode),
		.mirror_h    (mirror_h),
		.ram_en      (ram_en),
		.ram_wp      (ram_wp),
		.cfg_chr_ram (cfg_chr_ram),
		.prg_addr    (prg_addr),
		.chr_addr    (chr_addr),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.ram_ce      (ram_ce),
		.ram_we      (ram_we)
	);

	// a12 is the pattern table half select.
	a12_filter #(
		.FILTER_LEN (FILTER_LEN)
	) filt_i (
		.a12d       (a12d),
		.ctr_reload (ctr_reload),
		.ppu_a12    (ppu_addr[12]),
		.a12_rise   (a12_rise),
		.a12_fall   (a12_fall)
	);

	scanline_irq #(
		.EDGE_DIV (EDGE_DIV)
	) irq_i (
		.a12d         (a12d),
		.ctr_reload   (ctr_reload),
		.irq_op       (irq_op),
		.irq_wdata    (irq_wdata),
		.a12_rise     (a12_rise),
		.a12_fall     (a12_fall),
		.ss_we        (ss_we),
		.ss_addr      (ss_addr),
		.ss_wdata     (ss_wdata),
		.irq          (irq),
		.irq_ss_rdata (irq_ss_rdata)
	);

endmodule

/* hw/mapper_pkg.sv */
package mapper_pkg;

	// cpu register writes, decoded from a15..a13 and a0.
	typedef enum logic [3:0] {
		OP_NONE        = 4'd0,
		OP_BANK_SEL    = 4'd1, // $8000.
		OP_BANK_DATA   = 4'd2, // $8001.
		OP_MIRROR      = 4'd3, // $a000.
		OP_RAM_CTRL    = 4'd4, // $a001.
		OP_IRQ_LATCH   = 4'd5, // $c000.
		OP_IRQ_RELOAD  = 4'd6, // $c001.
		OP_IRQ_DISABLE = 4'd7, // $e000.
		OP_IRQ_ENABLE  = 4'd8  // $e001.
	} reg_op_e;

	// bank number widths.
	localparam int PRG_BANK_W = 6; // 64 x 8k of prg.
	localparam int CHR_BANK_W = 8; // 256 x 1k of chr.

	// save-state map.
	// addresses 0..7 are the bank registers themselves.
	localparam logic [7:0] SS_BANK_SEL  = 8'd8;
	localparam logic [7:0] SS_MIRROR    = 8'd9;
	localparam logic [7:0] SS_RAM_CTRL  = 8'd10;

	// irq block owns 16..23.
	localparam logic [7:0] SS_IRQ_LATCH = 8'd16;
	localparam logic [7:0] SS_IRQ_ON    = 8'd17; // only bit 0 is kept.
	localparam logic [7:0] SS_IRQ_CTR   = 8'd18;

endpackage

/* hw/scanline_irq.sv */
`timescale 1ns/10ps

module scanline_irq #(
	parameter int EDGE_DIV = 8
) (
	input  logic                a12d,
	input  logic                ctr_reload,
	input  mapper_pkg::reg_op_e irq_op,
	input  logic [7:0]          irq_wdata,
	input  logic                a12_rise,
	input  logic                a12_fall,
	input  logic                ss_we,
	input  logic [7:0]          ss_addr,
	input  logic [7:0]          ss_wdata,
	output logic                irq,
	output logic [7:0]          irq_ss_rdata
);
	import mapper_pkg::*;

	localparam int DIV_W = (EDGE_DIV > 1) ? $clog2(EDGE_DIV) : 1;

	logic [7:0]       irq_latch;
	logic [7:0]       irq_ctr;
	logic [7:0]       ctr_next;
	logic [DIV_W-1:0] edge_ctr;
	logic             irq_on;
	logic             irq_pend;
	logic             reload_pending;
	logic             irq_reload;
	logic             ctr_tick;
	logic             irq_trigger;

	assign irq_reload = irq_op == OP_IRQ_RELOAD; // $c001 strobe.
	assign ctr_tick   = a12_rise && (edge_ctr == '0);

	// reload from the latch on zero, else count down.
	assign ctr_next    = (irq_ctr == 8'd0) ? irq_latch : irq_ctr - 8'd1;
	assign irq_trigger = (ctr_next == 8'd0) && (irq_ctr != 8'd0 || reload_pending);

	always_ff @(posedge a12d or posedge ctr_reload)
	begin
		if (ctr_reload)
		begin
			irq_ctr        <= 8'd0;
			edge_ctr       <= '0;
			reload_pending <= 1'b0;
		end
		else if (irq_reload)
		begin
			irq_ctr        <= 8'd0;
			edge_ctr       <= '0;
			reload_pending <= 1'b1;
		end
		else
		begin
			if (a12_rise)
				edge_ctr <= (edge_ctr == DIV_W'(EDGE_DIV - 1)) ? '0 : edge_ctr + 1'b1;
			if (ctr_tick)
			begin
				irq_ctr        <= ctr_next;
				reload_pending <= 1'b0;
			end
			if (ss_we && ss_addr == SS_IRQ_CTR)
				irq_ctr <= ss_wdata;
		end
	end

	always_ff @(posedge a12d or posedge ctr_reload)
	begin
		if (ctr_reload)
		begin
			irq_latch <= 8'd0;
			irq_on    <= 1'b0;
			irq_pend  <= 1'b0;
			irq       <= 1'b0;
		end
		else
		begin
			if (ctr_tick && irq_trigger && irq_on)
				irq_pend <= 1'b1;
			// pending shows on the pin at the next a12 fall.
			if (a12_fall && irq_on)
				irq <= irq_pend;
			case (irq_op)
				OP_IRQ_LATCH: irq_latch <= irq_wdata;
				OP_IRQ_DISABLE:
				begin
					irq_on   <= 1'b0;
					irq_pend <= 1'b0; // acknowledge.
					irq      <= 1'b0;
				end
				OP_IRQ_ENABLE: irq_on <= 1'b1;
				default:       ;
			endcase
			if (ss_we && ss_addr == SS_IRQ_LATCH)
				irq_latch <= ss_wdata;
			if (ss_we && ss_addr == SS_IRQ_ON)
			begin
				irq_on <= ss_wdata[0];
				if (!ss_wdata[0])
				begin
					irq_pend <= 1'b0;
					irq      <= 1'b0;
				end
			end
		end
	end

	always_comb
	begin
		case (ss_addr)
			SS_IRQ_LATCH: irq_ss_rdata = irq_latch;
			SS_IRQ_ON:    irq_ss_rdata = {7'd0, irq_on};
			SS_IRQ_CTR:   irq_ss_rdata = irq_ctr;
			default:      irq_ss_rdata = 8'hff;
		endcase
	end

	a_div_range: assert property (@(posedge a12d) disable iff (ctr_reload)
		int'(edge_ctr) < EDGE_DIV)
		else $error("edge divider out of range");

	// disabling must drop the line in the same cycle as the enable.
	a_irq_off: assert property (@(posedge a12d) disable iff (ctr_reload)
		!irq_on |-> !irq)
		else $error("irq high while disabled");

endmodule

/* project.f */
+incdir+testbench
hw/mapper_pkg.sv
hw/bank_regs.sv
hw/addr_translate.sv
hw/a12_filter.sv
hw/scanline_irq.sv
hw/mapper_acclaim_top.sv
testbench/tb_mapper_acclaim.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the mapper testbench.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_mapper_acclaim \
	-o sim_mapper

./obj_dir/sim_mapper > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	exit 1
fi
exit 0

/* testbench/tb_mapper_tasks.svh */
`ifndef TB_MAPPER_TASKS_SVH
`define TB_MAPPER_TASKS_SVH

function automatic logic [18:0] exp_prg(input logic [15:0] a, input logic pm);
	logic [5:0] b;
	case (a[14:13])
		2'd0:    b = pm ? 6'h3e : bank_m[6][5:0];
		2'd1:    b = bank_m[7][5:0];
		2'd2:    b = pm ? bank_m[6][5:0] : 6'h3e;
		default: b = 6'h3f;
	endcase
	return {b, a[12:0]};
endfunction

function automatic logic [17:0] exp_chr(input logic [13:0] p, input logic cm, input logic cr);
	logic [2:0] r;
	logic [7:0] b;
	r = p[12:10] ^ {cm, 2'b00}; // region seen as if chr_mode were 0.
	if (r < 3'd4)
		b = {bank_m[{2'b00, r[1]}][7:1], p[10]};
	else
		b = bank_m[r - 3'd2];
	if (cr)
		b = b & 8'h1f;
	return {b, p[9:0]};
endfunction

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
	if (got !== exp)
	begin
		$display("[FAIL] %s: expected %h, got %h", name, exp, got);
		test_errs++;
	end
endtask

task automatic end_test(input string name);
	tests_run++;
	total_errs += test_errs;
	if (test_errs == 0)
		$display("test %s: ok", name);
	else
	begin
		$display("test %s: failed with %0d errors", name, test_errs);
		tests_failed++;
	end
	test_errs = 0;
endtask

task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
	@(posedge a12d);
	wr_valid <= 1'b1;
	cpu_addr <= a;
	cpu_data <= d;
	@(posedge a12d);
	wr_valid <= 1'b0;
endtask

task automatic ss_write(input logic [7:0] a, input logic [7:0] d);
	@(posedge a12d);
	ss_we    <= 1'b1;
	ss_addr  <= a;
	ss_wdata <= d;
	@(posedge a12d);
	ss_we <= 1'b0;
endtask

task automatic a12_pulse(input int high_cyc);
	@(posedge a12d);
	ppu_addr <= 14'h1000;
	repeat (high_cyc) @(posedge a12d);
	ppu_addr <= 14'h0000;
	repeat (PULSE_HALF) @(posedge a12d);
	@(negedge a12d);
endtask

// all four prg slots and all eight 1k chr regions.
task automatic check_map(input logic pm, input logic cm, input logic cr);
	logic [15:0] a;
	logic [13:0] p;
	int          i;
	@(posedge a12d);
	cfg_chr_ram <= cr;
	for (i = 0; i < 4; i++)
	begin
		a = {1'b1, 2'(i), 13'($random(seed))};
		@(posedge a12d);
		cpu_addr <= a;
		@(negedge a12d);
		check("prg_addr", 32'(exp_prg(a, pm)), 32'(prg_addr));
	end
	for (i = 0; i < 8; i++)
	begin
		p = {1'b0, 3'(i), 10'($random(seed))};
		@(posedge a12d);
		ppu_addr <= p;
		@(negedge a12d);
		check("chr_addr", 32'(exp_chr(p, cm, cr)), 32'(chr_addr));
	end
	@(posedge a12d);
	ppu_addr    <= 14'h0000;
	cfg_chr_ram <= 1'b0;
	repeat (PULSE_HALF) @(posedge a12d); // let the a12 filter settle low.
endtask

task automatic reset_defaults_test();
	bank_m = '{8'd0, 8'd2, 8'd4, 8'd5, 8'd6, 8'd7, 8'd0, 8'd1};
	check_map(1'b0, 1'b0, 1'b0);
	@(posedge a12d);
	ppu_addr <= 14'h2400;
	cpu_addr <= 16'h6000;
	@(negedge a12d);
	check("ciram_a10", 32'(cfg_mir_v), 32'(ciram_a10));
	check("ram_ce", 32'h0, 32'(ram_ce));
	check("irq", 32'h0, 32'(irq));
	@(posedge a12d);
	ppu_addr <= 14'h2800;
	@(negedge a12d);
	check("ciram_a10", 32'(!cfg_mir_v), 32'(ciram_a10));
	@(posedge a12d);
	ppu_addr <= 14'h0000;
	end_test("reset_defaults");
endtask

task automatic banking_test();
	int         i;
	int         m;
	logic [7:0] v;
	for (i = 0; i < 8; i++)
	begin
		v = 8'($random(seed));
		bank_m[i] = v;
		cpu_write(16'h8000, 8'(i));
		cpu_write(16'h8001, v);
	end
	for (m = 0; m < 4; m++)
	begin
		cpu_write(16'h8000, {m[1], m[0], 6'd0});
		check_map(m[0], m[1], 1'b0);
		check_map(m[0], m[1], 1'b1);
	end
	end_test("banking");
endtask

task automatic mirror_ram_test();
	cpu_write(16'ha000, 8'h00);
	@(posedge a12d);
	ppu_addr <= 14'h2400; // a10 set, a11 clear.
	@(negedge a12d);
	check("ciram_a10", 32'h1, 32'(ciram_a10));
	check("ciram_ce", 32'h0, 32'(ciram_ce));
	cpu_write(16'ha000, 8'h01);
	@(negedge a12d);
	check("ciram_a10", 32'h0, 32'(ciram_a10));
	@(posedge a12d);
	ppu_addr <= 14'h0800;
	@(negedge a12d);
	check("ciram_a10", 32'h1, 32'(ciram_a10));
	check("ciram_ce", 32'h1, 32'(ciram_ce));
	cpu_write(16'ha001, 8'h80); // enabled, writable.
	@(posedge a12d);
	ppu_addr <= 14'h0000;
	wr_valid <= 1'b1;
	cpu_addr <= 16'h6123;
	@(negedge a12d);
	check("ram_ce", 32'h1, 32'(ram_ce));
	check("ram_we", 32'h1, 32'(ram_we));
	@(posedge a12d);
	cpu_addr <= 16'h5fff;
	@(negedge a12d);
	check("ram_ce", 32'h0, 32'(ram_ce));
	@(posedge a12d);
	wr_valid <= 1'b0;
	cpu_write(16'ha001, 8'hc0); // enabled, protected.
	@(posedge a12d);
	wr_valid <= 1'b1;
	cpu_addr <= 16'h7ffe;
	@(negedge a12d);
	check("ram_ce", 32'h1, 32'(ram_ce));
	check("ram_we", 32'h0, 32'(ram_we));
	@(posedge a12d);
	wr_valid <= 1'b0;
	cpu_write(16'ha001, 8'h00);
	@(posedge a12d);
	cpu_addr <= 16'h6000;
	@(negedge a12d);
	check("ram_ce", 32'h0, 32'(ram_ce));
	end_test("mirror_ram");
endtask

task automatic scanline_irq_test();
	int n;
	int p;
	int fire;
	n = 1 + ($unsigned($random(seed)) % 3);
	fire = EDGE_DIV * n + 1;
	cpu_write(16'hc000, 8'(n));
	cpu_write(16'hc001, 8'h00);
	cpu_write(16'he001, 8'h00);
	for (p = 1; p <= fire; p++)
	begin
		a12_pulse(PULSE_HALF);
		check("irq", 32'(p == fire), 32'(irq));
	end
	cpu_write(16'he000, 8'h00);
	cpu_write(16'hc000, 8'h00); // a latch of 0 fires at once.
	cpu_write(16'hc001, 8'h00);
	cpu_write(16'he001, 8'h00);
	a12_pulse(PULSE_HALF);
	check("irq", 32'h1, 32'(irq));
	cpu_write(16'he000, 8'h00);
	end_test("scanline_irq");
endtask

task automatic glitch_disable_test();
	int p;
	cpu_write(16'hc000, 8'h01);
	cpu_write(16'hc001, 8'h00);
	cpu_write(16'he001, 8'h00);
	for (p = 1; p <= EDGE_DIV + 1; p++)
	begin
		if (p < 5)
		begin
			a12_pulse(1); // one-cycle glitch.
			check("irq", 32'h0, 32'(irq));
		end
		a12_pulse(PULSE_HALF);
		check("irq", 32'(p == EDGE_DIV + 1), 32'(irq));
	end
	cpu_write(16'he000, 8'h00);
	@(negedge a12d);
	check("irq", 32'h0, 32'(irq));
	cpu_write(16'he001, 8'h00);
	// reload on the next tick, trigger one tick later.
	for (p = 1; p < 2 * EDGE_DIV; p++)
	begin
		a12_pulse(PULSE_HALF);
		check("irq", 32'h0, 32'(irq));
	end
	a12_pulse(PULSE_HALF);
	check("irq", 32'h1, 32'(irq));
	cpu_write(16'he000, 8'h00);
	end_test("glitch_disable");
endtask

task automatic save_state_test();
	logic [7:0] v [0:18];
	logic [7:0] unused [0:6];
	int         i;
	unused = '{8'd11, 8'd15, 8'd19, 8'd23, 8'd24, 8'd127, 8'd200};
	for (i = 0; i < 19; i++)
	begin
		v[i] = 8'($random(seed));
		if (i <= 10 || i >= 16)
			ss_write(8'(i), v[i]);
	end
	for (i = 0; i < 19; i++)
	begin
		if (i <= 10 || i >= 16)
		begin
			@(posedge a12d);
			ss_addr <= 8'(i);
			@(negedge a12d);
			if (i == 17)
				check("ss_rdata", {31'd0, v[i][0]}, 32'(ss_rdata));
			else
				check("ss_rdata", 32'(v[i]), 32'(ss_rdata));
		end
	end
	for (i = 0; i < 7; i++)
	begin
		@(posedge a12d);
		ss_addr <= unused[i];
		@(negedge a12d);
		check("ss_rdata", 32'hff, 32'(ss_rdata));
	end
	for (i = 0; i < 8; i++)
		bank_m[i] = v[i];
	check_map(v[8][6], v[8][7], 1'b0);
	end_test("save_state");
endtask

`endif

/* testbench/tb_mapper_acclaim.sv */
`timescale 1ns/10ps

module tb_mapper_acclaim;
	import mapper_pkg::*;

	localparam int FILTER_LEN = 3;
	localparam int EDGE_DIV   = 8;
	localparam int CLK_PERIOD = 20;
	localparam int PULSE_HALF = FILTER_LEN + 5; // covers sync, filter and irq register.
	localparam int PULSE_CYC  = 2 * PULSE_HALF;

	// budget for the whole run.
	localparam int MAX_PULSES  = 80;
	localparam int MAX_WRITES  = 160;
	localparam int CHECK_CYC   = 400;
	localparam int WATCHDOG_NS = CLK_PERIOD *
		(8 + MAX_PULSES * PULSE_CYC + MAX_WRITES * 2 + CHECK_CYC);

	logic        a12d;
	logic        ctr_reload;
	logic        wr_valid;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic [13:0] ppu_addr;
	logic        ss_we;
	logic [7:0]  ss_addr;
	logic [7:0]  ss_wdata;
	logic        cfg_mir_v;
	logic        cfg_chr_ram;
	logic [18:0] prg_addr;
	logic [17:0] chr_addr;
	logic        ciram_a10;
	logic        ciram_ce;
	logic        ram_ce;
	logic        ram_we;
	logic        irq;
	logic [7:0]  ss_rdata;

	integer     seed;
	int         test_errs;
	int         total_errs;
	int         tests_run;
	int         tests_failed;
	logic [7:0] bank_m [0:7]; // expected bank registers.

	mapper_acclaim_top #(
		.FILTER_LEN (FILTER_LEN),
		.EDGE_DIV   (EDGE_DIV)
	) dut_i (
		.a12d        (a12d),
		.ctr_reload  (ctr_reload),
		.wr_valid    (wr_valid),
		.cpu_addr    (cpu_addr),
		.cpu_data    (cpu_data),
		.ppu_addr    (ppu_addr),
		.ss_we       (ss_we),
		.ss_addr     (ss_addr),
		.ss_wdata    (ss_wdata),
		.cfg_mir_v   (cfg_mir_v),
		.cfg_chr_ram (cfg_chr_ram),
		.prg_addr    (prg_addr),
		.chr_addr    (chr_addr),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.ram_ce      (ram_ce),
		.ram_we      (ram_we),
		.irq         (irq),
		.ss_rdata    (ss_rdata)
	);

	`include "tb_mapper_tasks.svh"

	always #(CLK_PERIOD / 2) a12d = ~a12d;

	// watchdog.
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		seed         = 32'h2f42;
		test_errs    = 0;
		total_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;
		a12d         = 1'b0;
		ctr_reload   = 1'b1;
		wr_valid     = 1'b0;
		cpu_addr     = 16'h0000;
		cpu_data     = 8'h00;
		ppu_addr     = 14'h0000;
		ss_we        = 1'b0;
		ss_addr      = 8'h00;
		ss_wdata     = 8'h00;
		cfg_mir_v    = 1'b1; // vertical, so ciram_a10 follows a10.
		cfg_chr_ram  = 1'b0;
		repeat (8) @(posedge a12d);
		ctr_reload <= 1'b0;
		@(posedge a12d);

		reset_defaults_test();
		banking_test();
		mirror_ram_test();
		scanline_irq_test();
		glitch_disable_test();
		save_state_test();

		$display("summary: %0d tests, %0d failed, %0d check errors",
			tests_run, tests_failed, total_errs);
		if (tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
